/* dv/tb_clock.sv */
// Free-running clock that starts low. PERIOD_NS should be even for a 50 percent duty cycle
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
        parameter int PERIOD_NS = 10
) (
        output logic clk
);

        initial begin
                clk = 1'b0;
                forever begin
                        #(PERIOD_NS / 2) clk = ~clk;
                end
        end

endmodule

`default_nettype wire

/* dv/tb_frame_relay.sv */
// Frame table and stall point are fixed here. Both links are driven on the falling clock edge
`default_nettype none
`timescale 1ns/1ps
`include "frame_macros.svh"

module tb_frame_relay;

        import frame_pkg::*;
        import link_pkg::*;

        localparam int RESET_CYCLES    = 5;
        localparam int N_FRAMES        = 6;
        localparam int N_PAYLOAD       = 21;
        localparam int TABLE_WORDS     = N_FRAMES + N_PAYLOAD;
        // Consumer holds off on the header of this frame
        localparam int STALL_FRAME     = 4;
        localparam int STALL_CYCLES    = 80;
        localparam int WATCHDOG_CYCLES = 200 * TABLE_WORDS;

        logic         clk;
        logic         rst_n;
        logic         in_req;
        frame_data_t  in_word;
        logic         out_ack;
        logic         in_ack;
        logic         out_req;
        tx_item_t     out_item;
        fifo_status_t status;

        logic [3:0]   frame_kind [N_FRAMES];
        logic [11:0]  frame_len  [N_FRAMES];
        frame_data_t  payload    [N_PAYLOAD];

        frame_data_t  in_words  [$];
        tx_item_t     exp_items [$];

        integer seed        = 74394;
        int     stall_index = -1;
        int     error_count = 0;
        int     full_waits  = 0;
        logic   prev_ack    = 1'b0;
        logic [`FIFO_LEVEL_W-1:0] prev_level = '0;

        tb_clock #(.PERIOD_NS(10)) u_clock (.clk(clk));

        frame_relay UUT (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_req   (in_req),
                .in_word  (in_word),
                .out_ack  (out_ack),
                .in_ack   (in_ack),
                .out_req  (out_req),
                .out_item (out_item),
                .status   (status)
        );

        task automatic abort_run();
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped on the first error");
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
                if (got !== want) begin
                        error_count++;
                        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t",
                                 name, got, want, $time);
                        abort_run();
                end
        endtask

        function automatic tx_item_t make_item(input frame_data_t w, input logic hdr,
                                               input logic chk);
                tx_item_t it;
                it.word      = w;
                it.is_header = hdr;
                it.is_check  = chk;
                return it;
        endfunction

        // Input words in order, expected output with one XOR word per frame
        task automatic build_tables();
                int          off;
                frame_data_t hdr;
                frame_data_t csum;
                frame_data_t w;
                frame_kind = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6};
                frame_len  = '{12'd3, 12'd0, 12'd5, 12'd1, 12'd12, 12'd0};
                payload    = '{16'hA5A5, 16'h0001, 16'hFFFF,
                               16'h1357, 16'h2468, 16'h8000, 16'h0F0F, 16'hC3C3,
                               16'h7E7E,
                               16'h0100, 16'h0202, 16'h0404, 16'h0808, 16'h1010, 16'h2020,
                               16'h4040, 16'h8080, 16'hDEAD, 16'hBEEF, 16'h5555, 16'hAAAA};
                off = 0;
                for (int f = 0; f < N_FRAMES; f++) begin
                        // Kind in the top nibble, len below
                        hdr = {frame_kind[f], frame_len[f]};
                        if (f == STALL_FRAME) begin
                                stall_index = exp_items.size();
                        end
                        in_words.push_back(hdr);
                        exp_items.push_back(make_item(hdr, 1'b1, 1'b0));
                        csum = hdr;
                        for (int i = 0; i < int'(frame_len[f]); i++) begin
                                w = payload[off + i];
                                csum = csum ^ w;
                                in_words.push_back(w);
                                exp_items.push_back(make_item(w, 1'b0, 1'b0));
                        end
                        off += int'(frame_len[f]);
                        exp_items.push_back(make_item(csum, 1'b0, 1'b1));
                end
        endtask

        // One four-phase exchange on the input link
        task automatic send_word(input frame_data_t w);
                @(negedge clk);
                in_word = w;
                in_req  = 1'b1;
                @(negedge clk);
                while (!in_ack) @(negedge clk);
                in_req = 1'b0;
                @(negedge clk);
                while (in_ack) @(negedge clk);
        endtask

        task automatic receive_item(input int idx);
                int       delay;
                tx_item_t want;
                want = exp_items[idx];
                while (!out_req) @(negedge clk);
                delay = int'($unsigned($random(seed)) % 8);
                if (idx == stall_index) begin
                        delay = delay + STALL_CYCLES;
                end
                repeat (delay) @(negedge clk);
                check_value("out_item.word", 32'(out_item.word), 32'(want.word));
                check_value("out_item.is_header", 32'(out_item.is_header), 32'(want.is_header));
                check_value("out_item.is_check", 32'(out_item.is_check), 32'(want.is_check));
                out_ack = 1'b1;
                @(negedge clk);
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
                @(negedge clk);
        endtask

        // Values seen here are the ones held before the edge
        always @(posedge clk) begin
                // A full FIFO with ack low must keep ack low on the next edge
                if (!prev_ack && (32'(prev_level) == `FIFO_DEPTH)) begin
                        check_value("in_ack", 32'(in_ack), 32'(0));
                end
                if ((32'(status.level) == `FIFO_DEPTH) && in_req && !in_ack) begin
                        full_waits = full_waits + 1;
                end
                prev_ack   = in_ack;
                prev_level = status.level;
        end

        initial begin
                rst_n   = 1'b0;
                in_req  = 1'b0;
                in_word = '0;
                out_ack = 1'b0;
                build_tables();
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                fork
                        begin : producer
                                foreach (in_words[i]) begin
                                        send_word(in_words[i]);
                                end
                        end
                        begin : consumer
                                for (int i = 0; i < exp_items.size(); i++) begin
                                        receive_item(i);
                                end
                        end
                join
                repeat (4) @(negedge clk);
                check_value("status.level", 32'(status.level), 32'(0));
                check_value("out_req", 32'(out_req), 32'(0));
                check_value("status.max_level", 32'(status.max_level), `FIFO_DEPTH);
                // Producer must have waited on a full FIFO during the stall
                if (full_waits == 0) begin
                        $display("The producer never waited on a full FIFO during the stall");
                        abort_run();
                end
                if (error_count == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

        initial begin
                repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
                $display("Timeout: the relay did not deliver all frames within %0d cycles",
                         WATCHDOG_CYCLES);
                abort_run();
        end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/frame_pkg.sv
src/link_pkg.sv
src/frame_rx.sv
src/sync_fifo.sv
src/frame_checker.sv
src/frame_tx.sv
src/frame_relay.sv
dv/tb_clock.sv
dv/tb_frame_relay.sv

/* run.sh */
#!/bin/sh
# Build and run the frame relay testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_frame_relay \
        --Mdir obj_dir -o Vtb_frame_relay

# The simulator exits non-zero on $fatal, so keep going and judge by the log
./obj_dir/Vtb_frame_relay > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
        echo "Simulation failed"
        exit 1
fi
echo "Simulation passed"

/* src/frame_checker.sv */
// Headers are trusted. Frame length comes from len with no check for malformed frames
`default_nettype none
`timescale 1ns/1ps

module frame_checker (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   empty,
        input  frame_pkg::frame_data_t data_out,
        input  logic                   item_taken,
        output logic                   pop,
        output link_pkg::tx_item_t     item,
        output logic                   item_valid
);

        import frame_pkg::*;

        typedef enum logic [1:0] {
                ST_HEADER,
                ST_PAYLOAD,
                ST_CHECK
        } chk_state_t;

        chk_state_t  state;
        logic        rd_pending;
        frame_word_u rd_word;
        frame_len_t  remain;
        frame_csum_t csum;

        // One read in flight and none while an item waits downstream
        assign pop = !empty && !item_valid && !rd_pending;

        always_comb begin
                rd_word.raw = data_out;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state      <= ST_HEADER;
                        rd_pending <= 1'b0;
                        item_valid <= 1'b0;
                        remain     <= '0;
                        csum       <= '0;
                end else begin
                        rd_pending <= pop;
                        if (rd_pending) begin
                                item_valid <= 1'b1;
                                csum       <= csum ^ rd_word.raw;
                                if (state == ST_HEADER) begin
                                        // Empty frame goes straight to its checksum
                                        remain <= rd_word.hdr.len;
                                        state  <= (rd_word.hdr.len == '0) ? ST_CHECK : ST_PAYLOAD;
                                end else begin
                                        remain <= remain - 1'b1;
                                        if (remain == frame_len_t'(1)) begin
                                                state <= ST_CHECK;
                                        end
                                end
                        end else if (item_taken) begin
                                if (state == ST_CHECK) begin
                                        // Checksum replaces the taken word without a pop
                                        csum  <= '0;
                                        state <= ST_HEADER;
                                end else begin
                                        item_valid <= 1'b0;
                                end
                        end
                end
        end

        // Holding register for the outgoing item
        always_ff @(posedge clk) begin
                if (rd_pending) begin
                        item.word      <= rd_word.raw;
                        item.is_header <= (state == ST_HEADER);
                        item.is_check  <= 1'b0;
                end else if (item_taken && (state == ST_CHECK)) begin
                        item.word      <= csum;
                        item.is_header <= 1'b0;
                        item.is_check  <= 1'b1;
                end
        end

endmodule

`default_nettype wire

/* src/frame_macros.svh */
// FRAME_WORD_W must stay 16 so the header fields fill one word. FIFO_DEPTH must be at least 2
`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

// Width of one frame word on both links
`define FRAME_WORD_W 16

// Entries between receiver and checker
`define FIFO_DEPTH 8

// Level values run from 0 up to FIFO_DEPTH inclusive
`define FIFO_LEVEL_W ($clog2(`FIFO_DEPTH) + 1)

`endif

/* src/frame_pkg.sv */
// Header layout is fixed at 4 kind bits and 12 len bits and needs a 16-bit frame word
`default_nettype none
`include "frame_macros.svh"

package frame_pkg;

        // Header field widths
        localparam int HDR_KIND_W = 4;
        localparam int HDR_LEN_W  = 12;

        // One raw word as it travels through the FIFO
        typedef logic [`FRAME_WORD_W-1:0] frame_data_t;

        typedef logic [HDR_KIND_W-1:0] frame_kind_t;
        typedef logic [HDR_LEN_W-1:0]  frame_len_t;

        // Header word with kind in the upper nibble
        typedef struct packed {
                frame_kind_t kind;
                // Number of payload words that follow
                frame_len_t  len;
        } frame_hdr_t;

        // Same word seen as payload bits or as a header
        typedef union packed {
                frame_data_t raw;
                frame_hdr_t  hdr;
        } frame_word_u;

        // Word appended after each payload, XOR of header and payload words
        typedef frame_data_t frame_csum_t;

endpackage

`default_nettype wire

/* src/frame_relay.sv */
// Both links are assumed synchronous to clk. status reports levels of the internal FIFO
`default_nettype none
`timescale 1ns/1ps
`include "frame_macros.svh"

module frame_relay (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   in_req,
        input  frame_pkg::frame_data_t in_word,
        input  logic                   out_ack,
        output logic                   in_ack,
        output logic                   out_req,
        output link_pkg::tx_item_t     out_item,
        output link_pkg::fifo_status_t status
);

        import frame_pkg::*;
        import link_pkg::*;

        // Receiver to FIFO
        frame_data_t data_in;
        logic        push;
        logic        full;

        // FIFO to checker
        frame_data_t data_out;
        logic        pop;
        logic        empty;

        // Checker to sender
        tx_item_t    item;
        logic        item_valid;
        logic        item_taken;

        frame_rx u_rx (
                .clk     (clk),
                .rst_n   (rst_n),
                .in_req  (in_req),
                .in_word (in_word),
                .full    (full),
                .in_ack  (in_ack),
                .push    (push),
                .data_in (data_in)
        );

        sync_fifo #(
                .WIDTH (`FRAME_WORD_W),
                .DEPTH (`FIFO_DEPTH)
        ) u_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .push     (push),
                .data_in  (data_in),
                .pop      (pop),
                .data_out (data_out),
                .full     (full),
                .empty    (empty),
                .status   (status)
        );

        frame_checker u_chk (
                .clk        (clk),
                .rst_n      (rst_n),
                .empty      (empty),
                .data_out   (data_out),
                .item_taken (item_taken),
                .pop        (pop),
                .item       (item),
                .item_valid (item_valid)
        );

        frame_tx u_tx (
                .clk        (clk),
                .rst_n      (rst_n),
                .item       (item),
                .item_valid (item_valid),
                .out_ack    (out_ack),
                .item_taken (item_taken),
                .out_req    (out_req),
                .out_item   (out_item)
        );

endmodule

`default_nettype wire

/* src/frame_rx.sv */
// Producer is assumed synchronous to clk. in_req is sampled without a synchronizer
`default_nettype none
`timescale 1ns/1ps

module frame_rx (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   in_req,
        input  frame_pkg::frame_data_t in_word,
        input  logic                   full,
        output logic                   in_ack,
        output logic                   push,
        output frame_pkg::frame_data_t data_in
);

        typedef enum logic {
                RX_IDLE,
                RX_ACK
        } rx_state_t;

        rx_state_t state;

        // Accept a fresh request only with room in the FIFO
        assign push    = in_req && (state == RX_IDLE) && !full;
        assign data_in = in_word;
        assign in_ack  = (state == RX_ACK);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= RX_IDLE;
                end else begin
                        case (state)
                                RX_IDLE: begin
                                        // Word goes into the FIFO on this edge
                                        if (push) begin
                                                state <= RX_ACK;
                                        end
                                end
                                RX_ACK: begin
                                        // Hold ack until the producer drops req
                                        if (!in_req) begin
                                                state <= RX_IDLE;
                                        end
                                end
                                default: begin
                                        state <= RX_IDLE;
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

/* src/frame_tx.sv */
// Consumer is assumed synchronous to clk. One item is on the output link at a time
`default_nettype none
`timescale 1ns/1ps

module frame_tx (
        input  logic               clk,
        input  logic               rst_n,
        input  link_pkg::tx_item_t item,
        input  logic               item_valid,
        input  logic               out_ack,
        output logic               item_taken,
        output logic               out_req,
        output link_pkg::tx_item_t out_item
);

        typedef enum logic [1:0] {
                TX_IDLE,
                TX_REQ,
                TX_DONE
        } tx_state_t;

        tx_state_t state;

        // Take a new item only between exchanges
        assign item_taken = item_valid && (state == TX_IDLE);
        assign out_req    = (state == TX_REQ);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= TX_IDLE;
                end else begin
                        case (state)
                                TX_IDLE: begin
                                        if (item_taken) begin
                                                state <= TX_REQ;
                                        end
                                end
                                TX_REQ: begin
                                        if (out_ack) begin
                                                state <= TX_DONE;
                                        end
                                end
                                TX_DONE: begin
                                        // Consumer must release ack before the next item
                                        if (!out_ack) begin
                                                state <= TX_IDLE;
                                        end
                                end
                                default: begin
                                        state <= TX_IDLE;
                                end
                        endcase
                end
        end

        // Item stays stable for the whole exchange
        always_ff @(posedge clk) begin
                if (item_taken) begin
                        out_item <= item;
                end
        end

endmodule

`default_nettype wire

/* src/link_pkg.sv */
// Level fields follow FIFO_LEVEL_W and assume the FIFO is built with FIFO_DEPTH entries
`default_nettype none
`include "frame_macros.svh"

package link_pkg;

        // Item from checker to output side
        typedef struct packed {
                frame_pkg::frame_data_t word;
                logic                   is_header;
                // Set only on the appended checksum word
                logic                   is_check;
        } tx_item_t;

        // Fill report of the FIFO
        typedef struct packed {
                logic [`FIFO_LEVEL_W-1:0] level;
                // Highest level seen since reset
                logic [`FIFO_LEVEL_W-1:0] max_level;
        } fifo_status_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
// Registered read only. Push while full and pop while empty are ignored. DEPTH must match FIFO_DEPTH
`default_nettype none
`timescale 1ns/1ps
`include "frame_macros.svh"

module sync_fifo #(
        parameter int WIDTH = `FRAME_WORD_W,
        parameter int DEPTH = `FIFO_DEPTH
) (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   push,
        input  logic [WIDTH-1:0]       data_in,
        input  logic                   pop,
        output logic [WIDTH-1:0]       data_out,
        output logic                   full,
        output logic                   empty,
        output link_pkg::fifo_status_t status
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int LVL_W = `FIFO_LEVEL_W;

        // Last pointer value before wrapping
        localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
        localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(DEPTH);

        logic [WIDTH-1:0] mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [LVL_W-1:0] count;
        logic [LVL_W-1:0] next_count;
        logic [LVL_W-1:0] max_count;
        logic             wr_en;
        logic             rd_en;

        assign wr_en = push && !full;
        assign rd_en = pop && !empty;

        assign full  = (count == LVL_FULL);
        assign empty = (count == '0);

        assign status = '{level: count, max_level: max_count};

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        mem[wr_ptr] <= data_in;
                end
        end

        // Circular pointers
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (wr_en) begin
                                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_en) begin
                                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
                        end
                end
        end

        // Read data lands one cycle after the pop
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        data_out <= mem[rd_ptr];
                end
        end

        always_comb begin
                case ({wr_en, rd_en})
                        2'b10:   next_count = count + 1'b1;
                        2'b01:   next_count = count - 1'b1;
                        default: next_count = count;
                endcase
        end

        // Level and high-water mark
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count     <= '0;
                        max_count <= '0;
                end else begin
                        count <= next_count;
                        if (next_count > max_count) begin
                                max_count <= next_count;
                        end
                end
        end

endmodule

`default_nettype wire
